/* source/dsc_geom_pkg.sv */
`default_nettype none

package dsc_geom_pkg;

	localparam int IMG_W     = 8;
	localparam int IMG_H     = 8;
	localparam int N_PIX     = IMG_W * IMG_H;
	localparam int K_SIZE    = 3;                // kernel edge
	localparam int TAPS      = K_SIZE * K_SIZE;
	localparam int DRAIN_CYC = 3;                // final tap to last output strobe

	typedef logic [5:0] pix_addr_t;
	typedef logic [2:0] coord_t;

	// kernel positions in raster order, row offset = tap / 3 - 1
	typedef enum logic [3:0] {
		TAP_NW = 4'd0,
		TAP_N  = 4'd1,
		TAP_NE = 4'd2,
		TAP_W  = 4'd3,
		TAP_C  = 4'd4,
		TAP_E  = 4'd5,
		TAP_SW = 4'd6,
		TAP_S  = 4'd7,
		TAP_SE = 4'd8
	} tap_t;

	typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

endpackage

`default_nettype wire

/* source/dsc_arith_pkg.sv */
`default_nettype none

package dsc_arith_pkg;

	localparam int PIX_W      = 14;
	localparam int OUT_W      = 24;
	localparam int N_CH_IN    = 2;
	localparam int N_CH_OUT   = 2;
	localparam int FRAC_BITS  = 8;   // 256 is unity gain
	localparam int N_WT       = 22;
	localparam int PW_WT_BASE = 18;  // depthwise block is N_CH_IN * 9 long

	typedef logic signed [PIX_W-1:0] pixel_t;
	typedef logic signed [PIX_W-1:0] weight_t;
	typedef logic signed [OUT_W-1:0] out_pix_t;
	typedef logic signed [31:0]      acc_t;
	typedef logic [4:0]              wt_addr_t;

	typedef pixel_t   [N_CH_IN-1:0]  pix_vec_t;  // channel c in element c
	typedef out_pix_t [N_CH_OUT-1:0] out_vec_t;

	// drop the weight fraction, then clamp into a signed field of w bits
	function automatic acc_t requant(input acc_t a, input int w);
		acc_t s;
		acc_t hi;
		acc_t lo;
		s  = a >>> FRAC_BITS;
		hi = (acc_t'(1) <<< (w - 1)) - acc_t'(1);
		lo = -(acc_t'(1) <<< (w - 1));
		if (s > hi)
			return hi;
		else if (s < lo)
			return lo;
		else
			return s;
	endfunction

endpackage

`default_nettype wire

/* source/frame_store.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_store import dsc_geom_pkg::*, dsc_arith_pkg::*; (
	input  wire            clk,
	input  wire            i_rst,
	input  wire            i_pix_valid,
	input  wire pix_vec_t  i_pix,
	input  wire            i_busy,
	input  wire pix_addr_t i_rd_addr,
	output pix_vec_t       o_rd_pix,
	output logic           o_frame_ready
);

	pix_vec_t  mem [N_PIX];
	pix_addr_t wr_ptr;
	logic      wr_en;

	// frame_ready cycle also blocked, scan has not started yet
	assign wr_en = i_pix_valid && !i_busy && !o_frame_ready;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= i_pix;
		o_rd_pix <= mem[i_rd_addr];  // one cycle read
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr        <= '0;
			o_frame_ready <= 1'b0;
		end else begin
			o_frame_ready <= 1'b0;
			if (wr_en) begin
				if (wr_ptr == pix_addr_t'(N_PIX - 1)) begin
					wr_ptr        <= '0;    // wrap for next frame
					o_frame_ready <= 1'b1;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
		end
	end

	// busy comes from the scan, so a strobe here means the source ignored it
	a_no_pix_while_busy: assert property (
		@(posedge clk) disable iff (i_rst)
		!(i_pix_valid && i_busy)
	);

endmodule

`default_nettype wire

/* source/weight_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module weight_bank import dsc_geom_pkg::*, dsc_arith_pkg::*; (
	input  wire                                 clk,
	input  wire                                 i_rst,
	input  wire                                 i_wt_we,
	input  wire wt_addr_t                       i_wt_addr,
	input  wire weight_t                        i_wt_data,
	input  wire                                 i_busy,
	input  wire tap_t                           i_tap,
	output weight_t [N_CH_IN-1:0]               o_dw_wt,
	output weight_t [N_CH_OUT*N_CH_IN-1:0]      o_pw_wt
);

	weight_t wt [N_WT];

	always_ff @(posedge clk) begin
		if (i_wt_we && !i_busy && (i_wt_addr < wt_addr_t'(N_WT)))
			wt[i_wt_addr] <= i_wt_data;
	end

	// depthwise weights follow the tap with one cycle latency
	always_ff @(posedge clk) begin
		for (int c = 0; c < N_CH_IN; c++) begin
			o_dw_wt[c] <= wt[wt_addr_t'(c * TAPS + int'(i_tap))];
		end
	end

	always_comb begin
		for (int k = 0; k < N_CH_OUT * N_CH_IN; k++) begin
			o_pw_wt[k] = wt[wt_addr_t'(PW_WT_BASE + k)];  // k = out * N_CH_IN + in
		end
	end

	// reload only between frames and inside the table
	a_wt_write_ok: assert property (
		@(posedge clk) disable iff (i_rst)
		i_wt_we |-> (!i_busy && (i_wt_addr < wt_addr_t'(N_WT)))
	);

endmodule

`default_nettype wire

/* source/window_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module window_scan import dsc_geom_pkg::*; (
	input  wire       clk,
	input  wire       i_rst,
	input  wire       i_frame_ready,
	output logic      o_busy,
	output pix_addr_t o_rd_addr,
	output tap_t      o_tap,
	output logic      o_tap_valid,
	output logic      o_pad,
	output logic      o_win_last,
	output logic      o_frame_last
);

	scan_state_t          state;
	coord_t               row;
	coord_t               col;
	tap_t                 tap;
	logic [DRAIN_CYC-1:0] drain;     // keeps busy up while the MACs empty
	logic                 win_end;
	logic                 frame_end;
	logic                 nb_pad;
	int                   nb_row;
	int                   nb_col;

	assign win_end   = (state == SCAN_RUN) && (tap == TAP_SE);
	assign frame_end = win_end && (row == coord_t'(IMG_H - 1))
		&& (col == coord_t'(IMG_W - 1));

	// neighbour of the current output position for this tap
	always_comb begin
		nb_row    = int'(row) + int'(tap) / K_SIZE - 1;
		nb_col    = int'(col) + int'(tap) % K_SIZE - 1;
		nb_pad    = (nb_row < 0) || (nb_row >= IMG_H) || (nb_col < 0) || (nb_col >= IMG_W);
		o_rd_addr = nb_pad ? '0 : pix_addr_t'(nb_row * IMG_W + nb_col);  // padded read is don't care
	end

	assign o_tap  = tap;
	assign o_busy = (state == SCAN_RUN) || (|drain);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= SCAN_IDLE;
			row   <= '0;
			col   <= '0;
			tap   <= TAP_NW;
			drain <= '0;
		end else begin
			drain <= drain >> 1;
			case (state)
				SCAN_IDLE: begin
					if (i_frame_ready) begin
						state <= SCAN_RUN;
						row   <= '0;
						col   <= '0;
						tap   <= TAP_NW;
					end
				end
				SCAN_RUN: begin
					if (tap != TAP_SE) begin
						tap <= tap_t'(tap + 4'd1);
					end else begin
						tap <= TAP_NW;
						if (col == coord_t'(IMG_W - 1)) begin
							col <= '0;
							row <= row + 1'b1;
						end else begin
							col <= col + 1'b1;
						end
						if (frame_end) begin
							state <= SCAN_IDLE;
							drain <= '1;
						end
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	// markers line up with read data from the memories
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_tap_valid  <= 1'b0;
			o_pad        <= 1'b0;
			o_win_last   <= 1'b0;
			o_frame_last <= 1'b0;
		end else begin
			o_tap_valid  <= (state == SCAN_RUN);
			o_pad        <= nb_pad;
			o_win_last   <= win_end;
			o_frame_last <= frame_end;
		end
	end

endmodule

`default_nettype wire

/* source/depthwise_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module depthwise_mac import dsc_arith_pkg::*; (
	input  wire                           clk,
	input  wire                           i_rst,
	input  wire                           i_tap_valid,
	input  wire                           i_pad,
	input  wire                           i_win_last,
	input  wire                           i_frame_last,
	input  wire pix_vec_t                 i_pix,
	input  wire weight_t [N_CH_IN-1:0]    i_dw_wt,
	output logic                          o_dw_valid,
	output pix_vec_t                      o_dw_vec,
	output logic                          o_dw_last
);

	acc_t acc     [N_CH_IN];
	acc_t acc_nxt [N_CH_IN];

	// padded taps contribute zero
	always_comb begin
		for (int c = 0; c < N_CH_IN; c++) begin
			if (i_pad)
				acc_nxt[c] = acc[c];
			else
				acc_nxt[c] = acc[c] + acc_t'(i_pix[c]) * acc_t'(i_dw_wt[c]);
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int c = 0; c < N_CH_IN; c++) begin
				acc[c] <= '0;
			end
			o_dw_valid <= 1'b0;
			o_dw_last  <= 1'b0;
		end else begin
			o_dw_valid <= 1'b0;
			o_dw_last  <= 1'b0;
			if (i_tap_valid) begin
				for (int c = 0; c < N_CH_IN; c++) begin
					acc[c] <= i_win_last ? '0 : acc_nxt[c];  // fresh start per window
				end
				o_dw_valid <= i_win_last;
				o_dw_last  <= i_win_last && i_frame_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_tap_valid && i_win_last) begin
			for (int c = 0; c < N_CH_IN; c++) begin
				o_dw_vec[c] <= pixel_t'(requant(acc_nxt[c], PIX_W));
			end
		end
	end

endmodule

`default_nettype wire

/* source/pointwise_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module pointwise_mac import dsc_geom_pkg::*, dsc_arith_pkg::*; (
	input  wire                                clk,
	input  wire                                i_rst,
	input  wire                                i_dw_valid,
	input  wire pix_vec_t                      i_dw_vec,
	input  wire                                i_dw_last,
	input  wire weight_t [N_CH_OUT*N_CH_IN-1:0] i_pw_wt,
	output logic                               o_out_valid,
	output out_vec_t                           o_out,
	output logic                               o_last
);

	acc_t mix [N_CH_OUT];

	// 1x1 mixing, one row of the matrix per output channel
	always_comb begin
		for (int o = 0; o < N_CH_OUT; o++) begin
			mix[o] = '0;
			for (int i = 0; i < N_CH_IN; i++) begin
				mix[o] = mix[o] + acc_t'(i_dw_vec[i]) * acc_t'(i_pw_wt[o * N_CH_IN + i]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_dw_valid) begin
			for (int o = 0; o < N_CH_OUT; o++) begin
				o_out[o] <= out_pix_t'(requant(mix[o], OUT_W));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_out_valid <= 1'b0;
			o_last      <= 1'b0;
		end else begin
			o_out_valid <= i_dw_valid;
			o_last      <= i_dw_valid && i_dw_last;
		end
	end

	// scan issues one window per TAPS cycles without gaps
	a_out_spacing: assert property (
		@(posedge clk) disable iff (i_rst)
		(o_out_valid && !o_last) |-> ##1 (!o_out_valid) [*TAPS-1] ##1 o_out_valid
	);

endmodule

`default_nettype wire

/* source/dsc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dsc_top import dsc_geom_pkg::*, dsc_arith_pkg::*; (
	input  wire            clk,
	input  wire            i_rst,
	input  wire            i_pix_valid,
	input  wire pix_vec_t  i_pix,
	input  wire            i_wt_we,
	input  wire wt_addr_t  i_wt_addr,
	input  wire weight_t   i_wt_data,
	output logic           o_out_valid,
	output out_vec_t       o_out,
	output logic           o_last,
	output logic           o_busy
);

	logic                              frame_ready;
	pix_addr_t                         rd_addr;
	pix_vec_t                          rd_pix;
	tap_t                              tap;
	logic                              tap_valid;
	logic                              pad;
	logic                              win_last;
	logic                              frame_last;
	weight_t [N_CH_IN-1:0]             dw_wt;
	weight_t [N_CH_OUT*N_CH_IN-1:0]    pw_wt;
	logic                              dw_valid;
	pix_vec_t                          dw_vec;
	logic                              dw_last;

	frame_store u_frame_store (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_pix_valid   (i_pix_valid),
		.i_pix         (i_pix),
		.i_busy        (o_busy),
		.i_rd_addr     (rd_addr),
		.o_rd_pix      (rd_pix),
		.o_frame_ready (frame_ready)
	);

	weight_bank u_weight_bank (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_wt_we   (i_wt_we),
		.i_wt_addr (i_wt_addr),
		.i_wt_data (i_wt_data),
		.i_busy    (o_busy),
		.i_tap     (tap),
		.o_dw_wt   (dw_wt),
		.o_pw_wt   (pw_wt)
	);

	window_scan u_window_scan (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_frame_ready (frame_ready),
		.o_busy        (o_busy),
		.o_rd_addr     (rd_addr),
		.o_tap         (tap),
		.o_tap_valid   (tap_valid),
		.o_pad         (pad),
		.o_win_last    (win_last),
		.o_frame_last  (frame_last)
	);

	depthwise_mac u_depthwise_mac (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_tap_valid  (tap_valid),
		.i_pad        (pad),
		.i_win_last   (win_last),
		.i_frame_last (frame_last),
		.i_pix        (rd_pix),
		.i_dw_wt      (dw_wt),
		.o_dw_valid   (dw_valid),
		.o_dw_vec     (dw_vec),
		.o_dw_last    (dw_last)
	);

	pointwise_mac u_pointwise_mac (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_dw_valid  (dw_valid),
		.i_dw_vec    (dw_vec),
		.i_dw_last   (dw_last),
		.i_pw_wt     (pw_wt),
		.o_out_valid (o_out_valid),
		.o_out       (o_out),
		.o_last      (o_last)
	);

endmodule

`default_nettype wire

/* tests/tb_dsc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dsc import dsc_geom_pkg::*, dsc_arith_pkg::*; ();

	localparam int TESTS       = 5;
	localparam int CYCLE_LIMIT = TESTS * 5 * (N_PIX * (TAPS + 1) + N_WT);

	typedef logic [$bits(pix_addr_t):0] count_t;  // holds N_PIX itself

	logic      clk;
	logic      i_rst;
	logic      i_pix_valid;
	pix_vec_t  i_pix;
	logic      i_wt_we;
	wt_addr_t  i_wt_addr;
	weight_t   i_wt_data;
	logic      o_out_valid;
	out_vec_t  o_out;
	logic      o_last;
	logic      o_busy;

	pixel_t    frame_pix [N_CH_IN][N_PIX];
	weight_t   wts [N_WT];
	out_pix_t  exp_out [N_CH_OUT][N_PIX];
	int        n_checks;
	int        n_errors;
	int        cycle;

	dsc_top dut (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_pix_valid (i_pix_valid),
		.i_pix       (i_pix),
		.i_wt_we     (i_wt_we),
		.i_wt_addr   (i_wt_addr),
		.i_wt_data   (i_wt_data),
		.o_out_valid (o_out_valid),
		.o_out       (o_out),
		.o_last      (o_last),
		.o_busy      (o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycle = 0;
		while (cycle < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle++;
		end
		$display("timeout after %0d cycles, the output stream never completed", cycle);
		$display(">>> FAIL");
		$finish;
	end

	task automatic check_out(input string name, input out_pix_t got, input out_pix_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	// arithmetic shift by the weight fraction, then clamp to a signed width
	function automatic longint shift_sat(input longint sum, input int width);
		longint s;
		longint hi;
		longint lo;
		s  = sum >>> FRAC_BITS;
		hi = (longint'(1) <<< (width - 1)) - 1;
		lo = -(longint'(1) <<< (width - 1));
		if (s > hi)
			return hi;
		if (s < lo)
			return lo;
		return s;
	endfunction

	// in-frame neighbours along one axis of a 3x3 window
	function automatic int span(input int idx, input int size);
		return (idx == 0 || idx == size - 1) ? 2 : 3;
	endfunction

	function automatic void model_frame();
		longint dw_sum;
		longint dwq [N_CH_IN];
		longint pw_sum;
		int     nr;
		int     nc;
		for (int r = 0; r < IMG_H; r++) begin
			for (int x = 0; x < IMG_W; x++) begin
				for (int c = 0; c < N_CH_IN; c++) begin
					dw_sum = 0;
					for (int t = 0; t < TAPS; t++) begin
						nr = r + t / 3 - 1;
						nc = x + t % 3 - 1;
						if (nr >= 0 && nr < IMG_H && nc >= 0 && nc < IMG_W)
							dw_sum += longint'(frame_pix[c][nr * IMG_W + nc])
								* longint'(wts[c * TAPS + t]);
					end
					dwq[c] = shift_sat(dw_sum, PIX_W);
				end
				for (int o = 0; o < N_CH_OUT; o++) begin
					pw_sum = 0;
					for (int i = 0; i < N_CH_IN; i++)
						pw_sum += dwq[i] * longint'(wts[PW_WT_BASE + o * N_CH_IN + i]);
					exp_out[o][r * IMG_W + x] = out_pix_t'(shift_sat(pw_sum, OUT_W));
				end
			end
		end
	endfunction

	function automatic void set_identity_pw();
		for (int o = 0; o < N_CH_OUT; o++)
			for (int i = 0; i < N_CH_IN; i++)
				wts[PW_WT_BASE + o * N_CH_IN + i] = (o == i) ? weight_t'(256) : '0;
	endfunction

	function automatic void randomize_moderate();
		for (int a = 0; a < N_WT; a++)
			wts[a] = weight_t'(rand_range(-384, 383));
		for (int p = 0; p < N_PIX; p++)
			for (int c = 0; c < N_CH_IN; c++)
				frame_pix[c][p] = pixel_t'(rand_range(-512, 511));
	endfunction

	task automatic load_weights();
		check_flag("o_busy before weight load", o_busy, 1'b0);
		for (int a = 0; a < N_WT; a++) begin
			@(posedge clk);
			i_wt_we   <= 1'b1;
			i_wt_addr <= wt_addr_t'(a);
			i_wt_data <= wts[a];
		end
		@(posedge clk);
		i_wt_we <= 1'b0;
	endtask

	task automatic send_frame();
		for (int p = 0; p < N_PIX; p++) begin
			@(posedge clk);
			i_pix_valid <= 1'b1;
			for (int c = 0; c < N_CH_IN; c++)
				i_pix[c] <= frame_pix[c][p];
		end
		@(posedge clk);
		i_pix_valid <= 1'b0;
	endtask

	task automatic collect_frame();
		count_t n_out;
		int     gap;
		logic   seen_last;
		n_out     = '0;
		gap       = 0;
		seen_last = 1'b0;
		while (!seen_last && n_out < count_t'(N_PIX)) begin
			@(negedge clk);
			gap++;
			if (o_out_valid) begin
				if (n_out == '0)
					check_flag("o_busy during scan", o_busy, 1'b1);
				else
					check_count("o_out_valid spacing", count_t'(gap), count_t'(TAPS));
				for (int o = 0; o < N_CH_OUT; o++)
					check_out($sformatf("o_out[%0d] pixel %0d", o, n_out), o_out[o],
						exp_out[o][n_out]);
				check_flag("o_last", o_last, n_out == count_t'(N_PIX - 1));
				if (o_last)
					check_flag("o_busy with o_last", o_busy, 1'b1);  // still up on the last output
				seen_last = o_last;
				n_out++;
				gap = 0;
			end else begin
				check_flag("o_last without o_out_valid", o_last, 1'b0);
			end
		end
		check_count("output count", n_out, count_t'(N_PIX));
		@(negedge clk);
		check_flag("o_busy after o_last", o_busy, 1'b0);  // falls one cycle after o_last
	endtask

	task automatic test_identity();
		for (int a = 0; a < N_WT; a++)
			wts[a] = '0;
		for (int c = 0; c < N_CH_IN; c++)
			wts[c * TAPS + int'(TAP_C)] = weight_t'(256);
		set_identity_pw();
		for (int p = 0; p < N_PIX; p++)
			for (int c = 0; c < N_CH_IN; c++) begin
				frame_pix[c][p] = pixel_t'($urandom);
				exp_out[c][p]   = out_pix_t'(frame_pix[c][p]);  // sign-extended input
			end
		load_weights();
		send_frame();
		collect_frame();
	endtask

	task automatic test_padding();
		int v [N_CH_IN];
		v[0] = 100;
		v[1] = -37;
		for (int a = 0; a < PW_WT_BASE; a++)
			wts[a] = weight_t'(256);
		set_identity_pw();
		for (int r = 0; r < IMG_H; r++)
			for (int x = 0; x < IMG_W; x++)
				for (int c = 0; c < N_CH_IN; c++) begin
					frame_pix[c][r * IMG_W + x] = pixel_t'(v[c]);
					exp_out[c][r * IMG_W + x] =
						out_pix_t'(span(r, IMG_H) * span(x, IMG_W) * v[c]);  // 4v, 6v or 9v
				end
		load_weights();
		send_frame();
		collect_frame();
	endtask

	task automatic test_mixing();
		randomize_moderate();
		model_frame();
		load_weights();
		send_frame();
		collect_frame();
	endtask

	task automatic test_saturation();
		longint sat_hi;
		longint sat_lo;
		sat_hi = (longint'(1) <<< (PIX_W - 1)) - 1;
		sat_lo = -(longint'(1) <<< (PIX_W - 1));
		for (int a = 0; a < PW_WT_BASE; a++)
			wts[a] = weight_t'(rand_range(3000, 4000));
		// out0 adds both clamped channels and out1 passes channel 0
		wts[PW_WT_BASE + 0] = weight_t'(256);
		wts[PW_WT_BASE + 1] = weight_t'(256);
		wts[PW_WT_BASE + 2] = weight_t'(256);
		wts[PW_WT_BASE + 3] = '0;
		for (int p = 0; p < N_PIX; p++) begin
			frame_pix[0][p] = pixel_t'(rand_range(6000, 8191));
			frame_pix[1][p] = pixel_t'(rand_range(-8192, -6000));
			exp_out[0][p]   = out_pix_t'(sat_hi + sat_lo);
			exp_out[1][p]   = out_pix_t'(sat_hi);
		end
		load_weights();
		send_frame();
		collect_frame();
	endtask

	task automatic test_back_to_back();
		for (int f = 0; f < 2; f++) begin
			randomize_moderate();
			model_frame();
			load_weights();  // reload between frames
			send_frame();
			collect_frame();
		end
	endtask

	initial begin
		n_checks    = 0;
		n_errors    = 0;
		void'($urandom(32'h30dd));
		i_rst       = 1'b1;
		i_pix_valid = 1'b0;
		i_pix       = '0;
		i_wt_we     = 1'b0;
		i_wt_addr   = '0;
		i_wt_data   = '0;
		repeat (4) @(posedge clk);
		i_rst <= 1'b0;
		@(negedge clk);
		check_flag("o_busy after reset", o_busy, 1'b0);
		check_flag("o_out_valid after reset", o_out_valid, 1'b0);
		check_flag("o_last after reset", o_last, 1'b0);

		test_identity();
		test_padding();
		test_mixing();
		test_saturation();
		test_back_to_back();

		$display("checks %0d, errors %0d, cycles %0d", n_checks, n_errors, cycle);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
source/dsc_geom_pkg.sv
source/dsc_arith_pkg.sv
source/frame_store.sv
source/weight_bank.sv
source/window_scan.sv
source/depthwise_mac.sv
source/pointwise_mac.sv
source/dsc_top.sv
tests/tb_dsc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f files.f --top-module tb_dsc -Mdir obj_dir -o tb_dsc \
	&& ./obj_dir/tb_dsc > sim.log 2>&1 \
	|| echo "build or simulation run ended with an error"

cat sim.log 2>/dev/null

grep -qx ">>> PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
